/* dv/bin_update_properties.sv */
// bin update control checks
// bound onto the sequencer, watches the clause strobe, write enables
// and the two status outputs
`timescale 1ns/1ns
`include "sat_bin_params.svh"
`default_nettype none

module bin_update_properties
(
    input wire                              clk,
    input wire                              rst,
    input wire [`SAT_CLAUSES_PER_BIN-1:0]   rd_carray_i,
    input wire                              c_we_i,
    input wire                              vs_we_i,
    input wire                              ls_we_i,
    input wire                              apply_update_i,
    input wire                              done_update_i
);

    int unsigned fail_cnt;

    initial
    begin
        fail_cnt = 0;
    end

    a_carray_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(rd_carray_i))
    else
    begin
        fail_cnt++;
        $error("clause strobe has more than one bit set");
    end

    // only the learnt half is ever strobed
    a_carray_learnt: assert property (@(posedge clk) disable iff (!rst)
        rd_carray_i[`SAT_CLAUSES_PER_BIN-1:`SAT_CLAUSES_PER_BIN/2] == '0)
    else
    begin
        fail_cnt++;
        $error("clause strobe outside the learnt half");
    end

    a_we_in_apply: assert property (@(posedge clk) disable iff (!rst)
        (c_we_i || vs_we_i || ls_we_i) |-> apply_update_i)
    else
    begin
        fail_cnt++;
        $error("memory write outside the update window");
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_update_i |=> !done_update_i)
    else
    begin
        fail_cnt++;
        $error("done held longer than one cycle");
    end

    a_apply_drop: assert property (@(posedge clk) disable iff (!rst)
        done_update_i |=> !apply_update_i)
    else
    begin
        fail_cnt++;
        $error("apply still high in the cycle after done");
    end

endmodule

bind update_bin bin_update_properties i_props (
    .clk            (clk),
    .rst            (rst),
    .rd_carray_i    (rd_carray_o),
    .c_we_i         (c_we_o),
    .vs_we_i        (vs_we_o),
    .ls_we_i        (ls_we_o),
    .apply_update_i (apply_update_o),
    .done_update_i  (done_update_o)
);

`default_nettype wire

/* dv/tb_bin_update.sv */
// bin write-back testbench
// loads bins over the host port, runs updates against an engine model
// and reads every touched memory word back against a reference model
`timescale 1ns/1ns
`include "sat_bin_params.svh"
`default_nettype none

module tb_bin_update;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_UPDATES = 5;
    localparam int DONE_WAIT   = 50;
    localparam int MEM_DEPTH   = 1 << `SAT_ADDR_W;

    logic                          clk;
    logic                          rst;
    logic                          start_update_i;
    sat_bin_pkg::bin_id_t          cur_bin_i;
    sat_bin_pkg::lvl_t             base_lvl_i;
    sat_bin_pkg::state_vec_t       var_states_i;
    sat_bin_pkg::state_vec_t       lvl_states_i;
    logic [`SAT_CLAUSES_PER_BIN-1:0] rd_carray_o;
    sat_bin_pkg::clause_t          clause_i;
    logic                          host_we_i;
    sat_ctrl_pkg::mem_sel_e        host_sel_i;
    sat_bin_pkg::addr_t            host_addr_i;
    sat_bin_pkg::state_t           host_wdata_i;
    sat_bin_pkg::state_t           host_rdata_o;
    logic                          apply_update_o;
    logic                          done_update_o;

    // engine reply table, one clause per strobe bit
    sat_bin_pkg::clause_t          clause_tbl [0:`SAT_CLAUSES_PER_BIN-1];

    // reference copies of the four bin memories
    sat_bin_pkg::clause_t          clause_ref [0:MEM_DEPTH-1];
    sat_bin_pkg::var_id_t          vbin_ref   [0:MEM_DEPTH-1];
    sat_bin_pkg::state_t           vstate_ref [0:MEM_DEPTH-1];
    sat_bin_pkg::state_t           lstate_ref [0:MEM_DEPTH-1];

    logic [31:0]                   rng;
    int                            errors;
    int                            checks;
    int                            tests_run;
    int                            tests_failed;
    int                            test_err_start;
    int                            prop_fails;

    bin_update_top i_bin_update_top (
        .clk            (clk),
        .rst            (rst),
        .start_update_i (start_update_i),
        .cur_bin_i      (cur_bin_i),
        .base_lvl_i     (base_lvl_i),
        .var_states_i   (var_states_i),
        .lvl_states_i   (lvl_states_i),
        .rd_carray_o    (rd_carray_o),
        .clause_i       (clause_i),
        .host_we_i      (host_we_i),
        .host_sel_i     (host_sel_i),
        .host_addr_i    (host_addr_i),
        .host_wdata_i   (host_wdata_i),
        .host_rdata_o   (host_rdata_o),
        .apply_update_o (apply_update_o),
        .done_update_o  (done_update_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // engine model answers the strobe in the same cycle
    always_comb
    begin
        clause_i = '0;
        for (int i = 0; i < `SAT_CLAUSES_PER_BIN; i++)
        begin
            if (rd_carray_o[i])
                clause_i = clause_tbl[i];
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sat_bin_pkg::addr_t bin_base(input int bin);
        return sat_bin_pkg::addr_t'((bin - 1) * `SAT_CLAUSES_PER_BIN + 1);
    endfunction

    task automatic check_val(input string name, input sat_bin_pkg::state_t exp,
                             input sat_bin_pkg::state_t act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err_start)
            tests_failed++;
        $display("test %-22s %s (%0d errors)", name,
                 (errors == test_err_start) ? "ok" : "failed", errors - test_err_start);
    endtask

    task automatic host_write(input sat_ctrl_pkg::mem_sel_e sel, input sat_bin_pkg::addr_t addr,
                              input sat_bin_pkg::state_t data);
        @(negedge clk);
        host_we_i    = 1'b1;
        host_sel_i   = sel;
        host_addr_i  = addr;
        host_wdata_i = data;
        @(negedge clk);
        host_we_i    = 1'b0;
    endtask

    // read data shows one cycle after the address
    task automatic host_read(input sat_ctrl_pkg::mem_sel_e sel, input sat_bin_pkg::addr_t addr,
                             output sat_bin_pkg::state_t data);
        @(negedge clk);
        host_sel_i  = sel;
        host_addr_i = addr;
        @(negedge clk);
        data = host_rdata_o;
    endtask

    task automatic check_idle();
        @(negedge clk);
        check_val("rd_carray_o", '0, sat_bin_pkg::state_t'(rd_carray_o));
        check_val("c_we", '0, sat_bin_pkg::state_t'(i_bin_update_top.c_we));
        check_val("vs_we", '0, sat_bin_pkg::state_t'(i_bin_update_top.vs_we));
        check_val("ls_we", '0, sat_bin_pkg::state_t'(i_bin_update_top.ls_we));
        check_val("apply_update_o", '0, sat_bin_pkg::state_t'(apply_update_o));
        check_val("done_update_o", '0, sat_bin_pkg::state_t'(done_update_o));
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
    endtask

    // kick off an update and leave it running
    task automatic start_partial_update(input int bin, input int lvl);
        @(negedge clk);
        cur_bin_i      = sat_bin_pkg::bin_id_t'(bin);
        base_lvl_i     = sat_bin_pkg::lvl_t'(lvl);
        start_update_i = 1'b1;
        @(negedge clk);
        start_update_i = 1'b0;
        @(negedge clk);
        check_val("apply_update_o", 1, sat_bin_pkg::state_t'(apply_update_o));
    endtask

    // random clause bin and a var bin of unique ids
    task automatic load_bin(input int bin);
        sat_bin_pkg::addr_t  base;
        sat_bin_pkg::var_id_t ids [0:`SAT_VARS_PER_BIN-1];
        sat_bin_pkg::var_id_t id;
        bit                  dup;
        base = bin_base(bin);
        for (int k = 0; k < `SAT_CLAUSES_PER_BIN; k++)
        begin
            rng = xorshift32(rng);
            clause_ref[base + k] = rng[`SAT_CLAUSE_W-1:0];
            host_write(sat_ctrl_pkg::CLAUSE, base + k, sat_bin_pkg::state_t'(clause_ref[base + k]));
        end
        for (int k = 0; k < `SAT_VARS_PER_BIN; k++)
        begin
            do
            begin
                rng = xorshift32(rng);
                id  = sat_bin_pkg::var_id_t'(rng[`SAT_ADDR_W-1:0]);
                dup = 1'b0;
                for (int j = 0; j < k; j++)
                begin
                    if (ids[j] == id)
                        dup = 1'b1;
                end
            end while (dup);
            ids[k] = id;
            vbin_ref[base + k] = id;
            host_write(sat_ctrl_pkg::VAR_BIN, base + k, sat_bin_pkg::state_t'(id));
        end
    endtask

    task automatic run_update(input int bin, input int lvl, input bit second_start);
        sat_bin_pkg::state_vec_t vvec;
        sat_bin_pkg::state_vec_t lvec;
        sat_bin_pkg::addr_t      base;
        int                      cyc;
        int                      pulses;
        for (int k = 0; k < `SAT_VARS_PER_BIN; k++)
        begin
            rng = xorshift32(rng);
            vvec[k] = rng[`SAT_STATE_W-1:0];
            rng = xorshift32(rng);
            lvec[k] = rng[`SAT_STATE_W-1:0];
            rng = xorshift32(rng);
            clause_tbl[k] = rng[`SAT_CLAUSE_W-1:0];
        end
        @(negedge clk);
        var_states_i   = vvec;
        lvl_states_i   = lvec;
        cur_bin_i      = sat_bin_pkg::bin_id_t'(bin);
        base_lvl_i     = sat_bin_pkg::lvl_t'(lvl);
        start_update_i = 1'b1;
        @(negedge clk);
        start_update_i = 1'b0;
        // engine moves on right after start
        var_states_i   = ~vvec;
        lvl_states_i   = ~lvec;
        cyc = 0;
        while (!done_update_o && cyc < DONE_WAIT)
        begin
            check_val("apply_update_o", 1, sat_bin_pkg::state_t'(apply_update_o));
            start_update_i = second_start && (cyc == 3);
            @(negedge clk);
            cyc++;
        end
        if (!done_update_o)
        begin
            $display("ERROR: bin %0d update gave no done pulse within %0d cycles",
                     bin, DONE_WAIT);
            errors++;
        end
        pulses = done_update_o ? 1 : 0;
        @(negedge clk);
        check_val("apply_update_o", 0, sat_bin_pkg::state_t'(apply_update_o));
        if (done_update_o)
            pulses++;
        // a second start, if honoured, would give a later done
        if (second_start)
        begin
            repeat (20)
            begin
                @(negedge clk);
                if (done_update_o)
                    pulses++;
            end
        end
        check_val("done_update_o pulses", 1, sat_bin_pkg::state_t'(pulses));
        base = bin_base(bin);
        for (int k = 0; k < `SAT_CLAUSES_PER_BIN / 2; k++)
            clause_ref[base + `SAT_CLAUSES_PER_BIN / 2 + k] = clause_tbl[k];
        for (int k = 0; k < `SAT_VARS_PER_BIN; k++)
            vstate_ref[vbin_ref[base + k][`SAT_ADDR_W-1:0]] = vvec[k];
        for (int k = 0; k < `SAT_LVLS_PER_BIN; k++)
            lstate_ref[sat_bin_pkg::addr_t'(lvl + k)] = lvec[k];
    endtask

    task automatic check_bin(input int bin, input int lvl);
        sat_bin_pkg::addr_t  base;
        sat_bin_pkg::addr_t  a;
        sat_bin_pkg::state_t rd;
        base = bin_base(bin);
        for (int k = 0; k < `SAT_CLAUSES_PER_BIN; k++)
        begin
            a = base + k;
            host_read(sat_ctrl_pkg::CLAUSE, a, rd);
            check_val($sformatf("host_rdata_o clause[%0d]", a),
                      sat_bin_pkg::state_t'(clause_ref[a]), rd);
            host_read(sat_ctrl_pkg::VAR_BIN, a, rd);
            check_val($sformatf("host_rdata_o var_bin[%0d]", a),
                      sat_bin_pkg::state_t'(vbin_ref[a]), rd);
            a = vbin_ref[base + k][`SAT_ADDR_W-1:0];
            host_read(sat_ctrl_pkg::VAR_STATE, a, rd);
            check_val($sformatf("host_rdata_o var_state[%0d]", a), vstate_ref[a], rd);
            a = sat_bin_pkg::addr_t'(lvl + k);
            host_read(sat_ctrl_pkg::LVL_STATE, a, rd);
            check_val($sformatf("host_rdata_o lvl_state[%0d]", a), lstate_ref[a], rd);
        end
    endtask

    initial
    begin
        #(NUM_UPDATES * 200 * CLK_PERIOD);
        $display("ERROR: watchdog expired, the run did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        rng            = 32'hf837;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        rst            = 1'b0;
        start_update_i = 1'b0;
        cur_bin_i      = '0;
        base_lvl_i     = '0;
        var_states_i   = '0;
        lvl_states_i   = '0;
        host_we_i      = 1'b0;
        host_sel_i     = sat_ctrl_pkg::CLAUSE;
        host_addr_i    = '0;
        host_wdata_i   = '0;
        for (int k = 0; k < `SAT_CLAUSES_PER_BIN; k++)
            clause_tbl[k] = '0;
        repeat (5) @(negedge clk);
        rst = 1'b1;

        begin_test();
        check_idle();
        end_test("reset outputs");

        begin_test();
        load_bin(3);
        run_update(3, 40, 1'b0);
        check_bin(3, 40);
        end_test("bin 3 update");

        begin_test();
        load_bin(10);
        run_update(10, 100, 1'b1);
        check_bin(10, 100);
        end_test("second start ignored");

        // partial writes land in bin 10, which is not read back again
        begin_test();
        start_partial_update(10, 200);
        pulse_reset();
        check_idle();
        end_test("reset mid run");

        // two bins loaded first so the updates run with no gap
        begin_test();
        load_bin(21);
        load_bin(5);
        run_update(21, 300, 1'b0);
        run_update(5, 7, 1'b0);
        check_bin(21, 300);
        check_bin(5, 7);
        end_test("back-to-back updates");

        prop_fails = i_bin_update_top.i_update.i_props.fail_cnt;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, errors, prop_fails);
        if (errors == 0 && tests_failed == 0 && prop_fails == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bin write-back testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_bin_update -o sim_bin_update

./obj_dir/sim_bin_update +verilator+error+limit+1000 | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* src.f */
+incdir+verilog
verilog/sat_bin_pkg.sv
verilog/sat_ctrl_pkg.sv
verilog/engine_snapshot.sv
verilog/update_bin.sv
verilog/bin_store.sv
verilog/bin_update_top.sv
dv/bin_update_properties.sv
dv/tb_bin_update.sv

/* verilog/bin_store.sv */
// bin memories
// clause, var bin, var state and level state RAMs with update write
// ports and a host port; update writes win while apply is high
`timescale 1ns/1ns
`include "sat_bin_params.svh"
`default_nettype none

module bin_store
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              apply_i,
    input  wire                              c_we_i,
    input  wire sat_bin_pkg::addr_t          c_addr_i,
    input  wire sat_bin_pkg::clause_t        c_data_i,
    input  wire sat_bin_pkg::addr_t          vbin_addr_i,
    output sat_bin_pkg::var_id_t             vbin_data_o,
    input  wire                              vs_we_i,
    input  wire sat_bin_pkg::addr_t          vs_addr_i,
    input  wire sat_bin_pkg::state_t         vs_data_i,
    input  wire                              ls_we_i,
    input  wire sat_bin_pkg::addr_t          ls_addr_i,
    input  wire sat_bin_pkg::state_t         ls_data_i,
    input  wire                              host_we_i,
    input  wire sat_ctrl_pkg::mem_sel_e      host_sel_i,
    input  wire sat_bin_pkg::addr_t          host_addr_i,
    input  wire sat_bin_pkg::state_t         host_wdata_i,
    output sat_bin_pkg::state_t              host_rdata_o
);

    sat_bin_pkg::clause_t  clause_mem [0:(1<<`SAT_ADDR_W)-1];
    sat_bin_pkg::var_id_t  vbin_mem   [0:(1<<`SAT_ADDR_W)-1];
    sat_bin_pkg::state_t   vstate_mem [0:(1<<`SAT_ADDR_W)-1];
    sat_bin_pkg::state_t   lstate_mem [0:(1<<`SAT_ADDR_W)-1];

    logic                  host_wr;
    logic                  cm_we;
    logic                  vb_we;
    logic                  vsm_we;
    logic                  lsm_we;

    // host writes are locked out during an update
    assign host_wr = host_we_i && !apply_i;

    assign cm_we  = apply_i ? c_we_i  : host_wr && (host_sel_i == sat_ctrl_pkg::CLAUSE);
    assign vb_we  = host_wr && (host_sel_i == sat_ctrl_pkg::VAR_BIN);
    assign vsm_we = apply_i ? vs_we_i : host_wr && (host_sel_i == sat_ctrl_pkg::VAR_STATE);
    assign lsm_we = apply_i ? ls_we_i : host_wr && (host_sel_i == sat_ctrl_pkg::LVL_STATE);

    always_ff @(posedge clk)
    begin
        if (cm_we)
            clause_mem[apply_i ? c_addr_i : host_addr_i] <=
                apply_i ? c_data_i : host_wdata_i[`SAT_CLAUSE_W-1:0];
        if (vb_we)
            vbin_mem[host_addr_i] <= host_wdata_i[`SAT_VAR_W-1:0];
        if (vsm_we)
            vstate_mem[apply_i ? vs_addr_i : host_addr_i] <= apply_i ? vs_data_i : host_wdata_i;
        if (lsm_we)
            lstate_mem[apply_i ? ls_addr_i : host_addr_i] <= apply_i ? ls_data_i : host_wdata_i;
    end

    // var id lookup for the sequencer
    always_ff @(posedge clk)
    begin
        vbin_data_o <= vbin_mem[vbin_addr_i];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            host_rdata_o <= '0;
        else
        begin
            case (host_sel_i)
                sat_ctrl_pkg::CLAUSE:
                    host_rdata_o <= sat_bin_pkg::state_t'(clause_mem[host_addr_i]);
                sat_ctrl_pkg::VAR_BIN:
                    host_rdata_o <= sat_bin_pkg::state_t'(vbin_mem[host_addr_i]);
                sat_ctrl_pkg::VAR_STATE:
                    host_rdata_o <= vstate_mem[host_addr_i];
                default:
                    host_rdata_o <= lstate_mem[host_addr_i];
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/bin_update_top.sv */
// bin write-back top
// snapshot, sequencer and bin memories for one bin update
`timescale 1ns/1ns
`include "sat_bin_params.svh"
`default_nettype none

module bin_update_top
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              start_update_i,
    input  wire sat_bin_pkg::bin_id_t        cur_bin_i,
    input  wire sat_bin_pkg::lvl_t           base_lvl_i,
    input  wire sat_bin_pkg::state_vec_t     var_states_i,
    input  wire sat_bin_pkg::state_vec_t     lvl_states_i,
    output logic [`SAT_CLAUSES_PER_BIN-1:0]  rd_carray_o,
    input  wire sat_bin_pkg::clause_t        clause_i,
    input  wire                              host_we_i,
    input  wire sat_ctrl_pkg::mem_sel_e      host_sel_i,
    input  wire sat_bin_pkg::addr_t          host_addr_i,
    input  wire sat_bin_pkg::state_t         host_wdata_i,
    output sat_bin_pkg::state_t              host_rdata_o,
    output logic                             apply_update_o,
    output logic                             done_update_o
);

    logic                          snap_capture;
    logic [`SAT_VARS_PER_BIN-1:0]  vs_sel;
    logic [`SAT_LVLS_PER_BIN-1:0]  ls_sel;
    sat_bin_pkg::state_t           snap_vs;
    sat_bin_pkg::state_t           snap_ls;

    logic                          c_we;
    sat_bin_pkg::addr_t            c_addr;
    sat_bin_pkg::clause_t          c_data;
    sat_bin_pkg::addr_t            vbin_addr;
    sat_bin_pkg::var_id_t          vbin_data;
    logic                          vs_we;
    sat_bin_pkg::addr_t            vs_addr;
    sat_bin_pkg::state_t           vs_data;
    logic                          ls_we;
    sat_bin_pkg::addr_t            ls_addr;
    sat_bin_pkg::state_t           ls_data;

    engine_snapshot i_snapshot (
        .clk          (clk),
        .rst          (rst),
        .capture_i    (snap_capture),
        .var_states_i (var_states_i),
        .lvl_states_i (lvl_states_i),
        .vs_sel_i     (vs_sel),
        .ls_sel_i     (ls_sel),
        .vs_o         (snap_vs),
        .ls_o         (snap_ls)
    );

    update_bin i_update (
        .clk            (clk),
        .rst            (rst),
        .start_update_i (start_update_i),
        .cur_bin_i      (cur_bin_i),
        .base_lvl_i     (base_lvl_i),
        .snap_capture_o (snap_capture),
        .rd_carray_o    (rd_carray_o),
        .clause_i       (clause_i),
        .vs_sel_o       (vs_sel),
        .ls_sel_o       (ls_sel),
        .vs_i           (snap_vs),
        .ls_i           (snap_ls),
        .c_we_o         (c_we),
        .c_addr_o       (c_addr),
        .c_data_o       (c_data),
        .vbin_addr_o    (vbin_addr),
        .vbin_data_i    (vbin_data),
        .vs_we_o        (vs_we),
        .vs_addr_o      (vs_addr),
        .vs_data_o      (vs_data),
        .ls_we_o        (ls_we),
        .ls_addr_o      (ls_addr),
        .ls_data_o      (ls_data),
        .apply_update_o (apply_update_o),
        .done_update_o  (done_update_o)
    );

    bin_store i_store (
        .clk          (clk),
        .rst          (rst),
        .apply_i      (apply_update_o),
        .c_we_i       (c_we),
        .c_addr_i     (c_addr),
        .c_data_i     (c_data),
        .vbin_addr_i  (vbin_addr),
        .vbin_data_o  (vbin_data),
        .vs_we_i      (vs_we),
        .vs_addr_i    (vs_addr),
        .vs_data_i    (vs_data),
        .ls_we_i      (ls_we),
        .ls_addr_i    (ls_addr),
        .ls_data_i    (ls_data),
        .host_we_i    (host_we_i),
        .host_sel_i   (host_sel_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o)
    );

endmodule

`default_nettype wire

/* verilog/engine_snapshot.sv */
// engine state snapshot
// holds the engine's var and level state vectors from update start
// and returns one slot of each by one-hot select
`timescale 1ns/1ns
`include "sat_bin_params.svh"
`default_nettype none

module engine_snapshot
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              capture_i,
    input  wire sat_bin_pkg::state_vec_t     var_states_i,
    input  wire sat_bin_pkg::state_vec_t     lvl_states_i,
    input  wire [`SAT_VARS_PER_BIN-1:0]      vs_sel_i,
    input  wire [`SAT_LVLS_PER_BIN-1:0]      ls_sel_i,
    output sat_bin_pkg::state_t              vs_o,
    output sat_bin_pkg::state_t              ls_o
);

    sat_bin_pkg::state_vec_t var_snap;
    sat_bin_pkg::state_vec_t lvl_snap;
    logic                    snap_valid;

    // engine may move on once this is taken
    always_ff @(posedge clk)
    begin
        if (capture_i)
        begin
            var_snap <= var_states_i;
            lvl_snap <= lvl_states_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            snap_valid <= 1'b0;
        else if (capture_i)
            snap_valid <= 1'b1;
    end

    // one-hot muxes, zero when nothing selected
    always_comb
    begin
        vs_o = '0;
        ls_o = '0;
        if (snap_valid)
        begin
            for (int i = 0; i < `SAT_VARS_PER_BIN; i++)
            begin
                if (vs_sel_i[i])
                    vs_o = vs_o | var_snap[i];
            end
            for (int j = 0; j < `SAT_LVLS_PER_BIN; j++)
            begin
                if (ls_sel_i[j])
                    ls_o = ls_o | lvl_snap[j];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sat_bin_params.svh */
// SAT bin geometry
// bin sizes and field widths shared by all write-back blocks
`default_nettype none

`ifndef SAT_BIN_PARAMS_SVH
`define SAT_BIN_PARAMS_SVH

// clause slots per bin, upper half holds learnt clauses
`define SAT_CLAUSES_PER_BIN 8
`define SAT_VARS_PER_BIN    8
`define SAT_LVLS_PER_BIN    8

`define SAT_VAR_W           12
`define SAT_LVL_W           16
`define SAT_STATE_W         30
`define SAT_BIN_ID_W        10

// every bin memory is 512 deep
`define SAT_ADDR_W          9

// two bits per literal slot
`define SAT_CLAUSE_W        16

`endif

`default_nettype wire

/* verilog/sat_bin_pkg.sv */
// SAT bin data types
// clause words, variable ids, states, levels, bin ids and addresses
`include "sat_bin_params.svh"
`default_nettype none

package sat_bin_pkg;

    // one clause, two bits per literal
    typedef logic [`SAT_CLAUSE_W-1:0] clause_t;

    typedef logic [`SAT_VAR_W-1:0] var_id_t;

    // var state and level state share one format
    typedef logic [`SAT_STATE_W-1:0] state_t;

    typedef logic [`SAT_LVL_W-1:0] lvl_t;

    typedef logic [`SAT_BIN_ID_W-1:0] bin_id_t;

    typedef logic [`SAT_ADDR_W-1:0] addr_t;

    // slot k of the engine's state vector
    typedef state_t [`SAT_VARS_PER_BIN-1:0] state_vec_t;

endpackage

`default_nettype wire

/* verilog/sat_ctrl_pkg.sv */
// SAT bin control encodings
// sequencer states and host memory select
`default_nettype none

package sat_ctrl_pkg;

    typedef enum logic [1:0] {IDLE, UPDATE, DONE} upd_state_e;

    // host target memory
    typedef enum logic [1:0] {CLAUSE, VAR_BIN, VAR_STATE, LVL_STATE} mem_sel_e;

endpackage

`default_nettype wire

/* verilog/update_bin.sv */
// bin update sequencer
// turns one start pulse into the learnt clause, var state and
// level state write streams, then pulses done after the last write
`timescale 1ns/1ns
`include "sat_bin_params.svh"
`default_nettype none

module update_bin
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              start_update_i,
    input  wire sat_bin_pkg::bin_id_t        cur_bin_i,
    input  wire sat_bin_pkg::lvl_t           base_lvl_i,
    output logic                             snap_capture_o,
    output logic [`SAT_CLAUSES_PER_BIN-1:0]  rd_carray_o,
    input  wire sat_bin_pkg::clause_t        clause_i,
    output logic [`SAT_VARS_PER_BIN-1:0]     vs_sel_o,
    output logic [`SAT_LVLS_PER_BIN-1:0]     ls_sel_o,
    input  wire sat_bin_pkg::state_t         vs_i,
    input  wire sat_bin_pkg::state_t         ls_i,
    output logic                             c_we_o,
    output sat_bin_pkg::addr_t               c_addr_o,
    output sat_bin_pkg::clause_t             c_data_o,
    output sat_bin_pkg::addr_t               vbin_addr_o,
    input  wire sat_bin_pkg::var_id_t        vbin_data_i,
    output logic                             vs_we_o,
    output sat_bin_pkg::addr_t               vs_addr_o,
    output sat_bin_pkg::state_t              vs_data_o,
    output logic                             ls_we_o,
    output sat_bin_pkg::addr_t               ls_addr_o,
    output sat_bin_pkg::state_t              ls_data_o,
    output logic                             apply_update_o,
    output logic                             done_update_o
);

    sat_ctrl_pkg::upd_state_e        state_q;
    sat_ctrl_pkg::upd_state_e        state_d;
    sat_bin_pkg::addr_t              bin_base;
    sat_bin_pkg::addr_t              base_q;
    sat_bin_pkg::lvl_t               lvl_base_q;
    sat_bin_pkg::lvl_t               lvl_cur;
    logic [`SAT_VARS_PER_BIN-1:0]    vbin_rd;
    logic [3:0]                      c_cnt;
    logic [3:0]                      v_cnt;
    logic [3:0]                      l_cnt;
    logic                            start_ok;
    logic                            streams_end;

    assign start_ok       = start_update_i && (state_q == sat_ctrl_pkg::IDLE);
    assign snap_capture_o = start_ok;

    // bin n starts at (n-1)*8+1
    assign bin_base = sat_bin_pkg::addr_t'(cur_bin_i - 1'b1)
                    * sat_bin_pkg::addr_t'(`SAT_CLAUSES_PER_BIN)
                    + sat_bin_pkg::addr_t'(1);

    assign streams_end = (c_cnt == `SAT_CLAUSES_PER_BIN / 2)
                      && (v_cnt == `SAT_VARS_PER_BIN)
                      && (l_cnt == `SAT_LVLS_PER_BIN);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            sat_ctrl_pkg::IDLE:   if (start_update_i) state_d = sat_ctrl_pkg::UPDATE;
            sat_ctrl_pkg::UPDATE: if (streams_end) state_d = sat_ctrl_pkg::DONE;
            // last var state write drains here
            sat_ctrl_pkg::DONE:   state_d = sat_ctrl_pkg::IDLE;
            default:              state_d = sat_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            state_q <= sat_ctrl_pkg::IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            base_q     <= bin_base;
            lvl_base_q <= base_lvl_i;
        end
    end

    // one-hot strobes for the three streams
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rd_carray_o <= '0;
            vbin_rd     <= '0;
            ls_sel_o    <= '0;
            vs_sel_o    <= '0;
        end
        else
        begin
            vs_sel_o <= vbin_rd;
            if (start_ok)
            begin
                rd_carray_o <= `SAT_CLAUSES_PER_BIN'(1);
                vbin_rd     <= `SAT_VARS_PER_BIN'(1);
                ls_sel_o    <= `SAT_LVLS_PER_BIN'(1);
            end
            else
            begin
                // only the learnt half is walked
                rd_carray_o <= rd_carray_o[`SAT_CLAUSES_PER_BIN/2-1] ? '0 : rd_carray_o << 1;
                vbin_rd     <= vbin_rd << 1;
                ls_sel_o    <= ls_sel_o << 1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst || start_ok)
        begin
            c_cnt <= '0;
            v_cnt <= '0;
            l_cnt <= '0;
        end
        else
        begin
            if (|rd_carray_o)
                c_cnt <= c_cnt + 1'b1;
            if (|vbin_rd)
                v_cnt <= v_cnt + 1'b1;
            if (|ls_sel_o)
                l_cnt <= l_cnt + 1'b1;
        end
    end

    assign vbin_addr_o = base_q + sat_bin_pkg::addr_t'(v_cnt);
    assign lvl_cur     = lvl_base_q + sat_bin_pkg::lvl_t'(l_cnt);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            c_we_o  <= 1'b0;
            vs_we_o <= 1'b0;
            ls_we_o <= 1'b0;
        end
        else
        begin
            c_we_o  <= |rd_carray_o;
            vs_we_o <= |vs_sel_o;
            ls_we_o <= |ls_sel_o;
        end
    end

    always_ff @(posedge clk)
    begin
        c_addr_o  <= base_q + sat_bin_pkg::addr_t'(`SAT_CLAUSES_PER_BIN / 2)
                   + sat_bin_pkg::addr_t'(c_cnt);
        c_data_o  <= clause_i;
        // var id from the var bin is the state address
        vs_addr_o <= vbin_data_i[`SAT_ADDR_W-1:0];
        vs_data_o <= vs_i;
        ls_addr_o <= lvl_cur[`SAT_ADDR_W-1:0];
        ls_data_o <= ls_i;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            apply_update_o <= 1'b0;
            done_update_o  <= 1'b0;
        end
        else
        begin
            done_update_o <= (state_q == sat_ctrl_pkg::DONE);
            if (start_ok)
                apply_update_o <= 1'b1;
            else if (done_update_o)
                apply_update_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire
